//--- source/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef enum logic [3:0] {
        SB  = 4'd0,
        SH  = 4'd1,
        SW  = 4'd2,
        SWL = 4'd3,
        SWR = 4'd4,
        LBU = 4'd5,
        LB  = 4'd6,
        LHU = 4'd7,
        LH  = 4'd8,
        LWL = 4'd9,
        LWR = 4'd10,
        LW  = 4'd11,
        LL  = 4'd12,
        SC  = 4'd13
    } mem_op_e;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_MOD  = 5'd1;  // Store to clean page
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;

    localparam logic [2:0] CCA_CACHEABLE = 3'd3;  // Cacheable noncoherent
    localparam logic [2:0] SEG_KSEG0     = 3'd4;  // vaddr[31:29]
    localparam logic [2:0] SEG_KSEG1     = 3'd5;

    // kuseg, kseg2 and kseg3 go through the TLB
    function automatic logic is_mapped(input logic [31:0] vaddr);
        return !vaddr[31] || (vaddr[31] && vaddr[30]);
    endfunction

endpackage

//--- source/mem_access_pkg.sv
package mem_access_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;
    typedef logic [19:0] pfn_t;
    typedef logic [3:0]  lane_mask_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  cca_t;
    typedef logic [1:0]  size_t;  // 0 byte, 1 half, 2 word

    localparam int LANES            = 4;
    localparam int PAGE_OFFSET_BITS = 12;

    typedef struct packed {
        logic found;
        logic valid;
        logic dirty;
        pfn_t pfn;
        cca_t cca;
    } tlb_result_t;

    typedef struct packed {
        vaddr_t                vaddr;
        mips_isa_pkg::mem_op_e op;
        word_t                 rt;     // Store source register
        tlb_result_t           tlb;
    } mem_req_t;

    typedef struct packed {
        logic                    exc;
        logic                    refill;
        mips_isa_pkg::exc_code_t code;
        vaddr_t                  badvaddr;
    } exc_info_t;

    typedef struct packed {
        paddr_t     paddr;
        logic       uncached;
        lane_mask_t wr_lanes;
        word_t      wdata;
        lane_mask_t rd_lanes;
        logic       rd_signed;
        size_t      size;
        logic       sc_ok;
        exc_info_t  fault;
    } mem_resp_t;

endpackage

//--- source/access_ctrl.sv
`timescale 1ns/10ps

module access_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  mem_access_pkg::mem_req_t   req_in,
    input  mem_access_pkg::paddr_t     paddr,
    input  logic                       uncached,
    input  mem_access_pkg::exc_info_t  fault,
    input  logic                       sc_ok,
    input  mem_access_pkg::lane_mask_t lane_strobe,
    input  mem_access_pkg::word_t      lane_data,
    input  mem_access_pkg::lane_mask_t rd_lanes,
    input  logic                       rd_signed,
    input  mem_access_pkg::size_t      size,
    output logic                       ack,
    output mem_access_pkg::mem_req_t   held,
    output logic                       commit,
    output mem_access_pkg::mem_resp_t  resp
);

    typedef enum logic [1:0] {
        IDLE,
        EVAL,
        DONE
    } state_e;

    state_e                    state;
    state_e                    state_nxt;
    logic                      wr_kill;
    mem_access_pkg::mem_resp_t resp_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_nxt = EVAL;
                end
            end
            EVAL: begin
                state_nxt = DONE;  // Response ready after one cycle
            end
            DONE: begin
                if (!req) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            held <= req_in;
        end
    end

    assign commit = (state == EVAL);
    assign ack    = (state == DONE);  // Held through back-pressure

    // A failed SC must not reach memory
    assign wr_kill = fault.exc || (held.op == mips_isa_pkg::SC && !sc_ok);

    always_comb begin
        resp_nxt           = '0;
        resp_nxt.paddr     = paddr;
        resp_nxt.uncached  = uncached;
        resp_nxt.wr_lanes  = wr_kill ? '0 : lane_strobe;
        resp_nxt.wdata     = wr_kill ? '0 : lane_data;
        resp_nxt.rd_lanes  = fault.exc ? '0 : rd_lanes;
        resp_nxt.rd_signed = rd_signed;
        resp_nxt.size      = size;
        resp_nxt.sc_ok     = sc_ok;
        resp_nxt.fault     = fault;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp <= '0;
        end else if (commit) begin
            resp <= resp_nxt;
        end
    end

endmodule

//--- source/addr_translate.sv
`timescale 1ns/10ps

module addr_translate (
    input  mem_access_pkg::mem_req_t held,
    input  mem_access_pkg::cca_t     config_k0,
    output mem_access_pkg::paddr_t   paddr,
    output logic                     uncached
);

    localparam int OFS = mem_access_pkg::PAGE_OFFSET_BITS;

    logic       mapped;
    logic       kseg0;
    logic       kseg1;
    logic [2:0] seg;

    assign seg    = held.vaddr[31:29];
    assign mapped = mips_isa_pkg::is_mapped(held.vaddr);
    assign kseg0  = (seg == mips_isa_pkg::SEG_KSEG0);
    assign kseg1  = (seg == mips_isa_pkg::SEG_KSEG1);

    always_comb begin
        if (mapped) begin
            paddr = {held.tlb.pfn, held.vaddr[OFS-1:0]};
        end else begin
            paddr = {3'b000, held.vaddr[28:0]};  // Direct window
        end
    end

    // kseg1 is always uncached, kseg0 follows Config.K0
    assign uncached = kseg1
                   || (kseg0 && config_k0 != mips_isa_pkg::CCA_CACHEABLE)
                   || (mapped && held.tlb.cca != mips_isa_pkg::CCA_CACHEABLE);

endmodule

//--- source/access_fault.sv
`timescale 1ns/10ps

module access_fault (
    input  mem_access_pkg::mem_req_t  held,
    output mem_access_pkg::exc_info_t fault
);

    logic mapped;
    logic is_store;
    logic ades;
    logic adel;
    logic addr_err;
    logic tlb_miss;
    logic tlb_inv;
    logic tlb_mod;
    logic ofs_half;
    logic ofs_word;

    assign mapped   = mips_isa_pkg::is_mapped(held.vaddr);
    assign ofs_half = held.vaddr[0];
    assign ofs_word = (held.vaddr[1:0] != 2'b00);

    always_comb begin
        case (held.op)
            mips_isa_pkg::SB, mips_isa_pkg::SH, mips_isa_pkg::SW,
            mips_isa_pkg::SWL, mips_isa_pkg::SWR, mips_isa_pkg::SC: is_store = 1'b1;
            default: is_store = 1'b0;
        endcase
    end

    // SWL/SWR/LWL/LWR are unaligned by design
    assign ades = (held.op == mips_isa_pkg::SH && ofs_half)
               || ((held.op == mips_isa_pkg::SW || held.op == mips_isa_pkg::SC) && ofs_word);
    assign adel = ((held.op == mips_isa_pkg::LH || held.op == mips_isa_pkg::LHU) && ofs_half)
               || ((held.op == mips_isa_pkg::LW || held.op == mips_isa_pkg::LL) && ofs_word);
    assign addr_err = ades || adel;

    assign tlb_miss = mapped && !held.tlb.found;
    assign tlb_inv  = mapped && !(held.tlb.found && held.tlb.valid);  // Includes miss
    assign tlb_mod  = mapped && is_store && held.tlb.found && held.tlb.valid
                   && !held.tlb.dirty;

    always_comb begin
        fault        = '0;
        fault.exc    = addr_err || tlb_inv || tlb_mod;
        fault.refill = !addr_err && tlb_miss;
        if (ades) begin
            fault.code = mips_isa_pkg::EXC_ADES;
        end else if (adel) begin
            fault.code = mips_isa_pkg::EXC_ADEL;
        end else if (tlb_inv) begin
            fault.code = is_store ? mips_isa_pkg::EXC_TLBS : mips_isa_pkg::EXC_TLBL;
        end else if (tlb_mod) begin
            fault.code = mips_isa_pkg::EXC_MOD;
        end
        if (fault.exc) begin
            fault.badvaddr = held.vaddr;
        end
    end

endmodule

//--- source/link_monitor.sv
`timescale 1ns/10ps

module link_monitor (
    input  logic                     clk,
    input  logic                     rst,
    input  mem_access_pkg::mem_req_t held,
    input  logic                     commit,
    input  logic                     fault_exc,
    output logic                     sc_ok
);

    logic                   link;
    mem_access_pkg::vaddr_t link_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            link <= 1'b0;
        end else if (commit) begin
            if (fault_exc) begin
                link <= 1'b0;  // Any exception breaks the RMW sequence
            end else if (held.op == mips_isa_pkg::LL) begin
                link <= 1'b1;
            end else if (held.op == mips_isa_pkg::SC) begin
                link <= 1'b0;  // Pass or fail
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit && !fault_exc && held.op == mips_isa_pkg::LL) begin
            link_addr <= held.vaddr;
        end
    end

    assign sc_ok = link && held.op == mips_isa_pkg::SC
                && link_addr == held.vaddr && !fault_exc;

endmodule

//--- source/byte_lane.sv
`timescale 1ns/10ps

module byte_lane #(
    parameter int LANE = 0
) (
    input  mem_access_pkg::mem_req_t held,
    output logic                     strobe,
    output mem_access_pkg::byte_t    data
);

    localparam logic [1:0] IDX = LANE[1:0];

    logic [1:0]            k;
    mem_access_pkg::word_t swl_word;
    mem_access_pkg::word_t swr_word;
    mem_access_pkg::byte_t lane_byte;

    assign k        = held.vaddr[1:0];
    assign swl_word = held.rt >> {2'd3 - k, 3'b000};  // Upper bytes toward lane 0
    assign swr_word = held.rt << {k, 3'b000};

    always_comb begin
        strobe    = 1'b0;
        lane_byte = '0;
        case (held.op)
            mips_isa_pkg::SB: begin
                strobe    = (k == IDX);
                lane_byte = held.rt[7:0];
            end
            mips_isa_pkg::SH: begin
                strobe    = (k[1] == IDX[1]);
                lane_byte = IDX[0] ? held.rt[15:8] : held.rt[7:0];
            end
            mips_isa_pkg::SWL: begin
                strobe    = (IDX <= k);
                lane_byte = swl_word[8*LANE +: 8];
            end
            mips_isa_pkg::SWR: begin
                strobe    = (IDX >= k);
                lane_byte = swr_word[8*LANE +: 8];
            end
            mips_isa_pkg::SW, mips_isa_pkg::SC: begin
                strobe    = 1'b1;
                lane_byte = held.rt[8*LANE +: 8];
            end
            default: begin
                strobe = 1'b0;  // Loads
            end
        endcase
    end

    assign data = strobe ? lane_byte : '0;

endmodule

//--- source/load_format.sv
`timescale 1ns/10ps

module load_format (
    input  mem_access_pkg::mem_req_t   held,
    output mem_access_pkg::lane_mask_t rd_lanes,
    output logic                       rd_signed,
    output mem_access_pkg::size_t      size
);

    logic [1:0] k;

    assign k = held.vaddr[1:0];

    always_comb begin
        case (held.op)
            mips_isa_pkg::LB, mips_isa_pkg::LBU: rd_lanes = 4'b0001 << k;
            mips_isa_pkg::LH, mips_isa_pkg::LHU: rd_lanes = k[1] ? 4'b1100 : 4'b0011;
            mips_isa_pkg::LWL: begin
                case (k)
                    2'd0:    rd_lanes = 4'b0001;
                    2'd1:    rd_lanes = 4'b0011;
                    2'd2:    rd_lanes = 4'b0111;
                    default: rd_lanes = 4'b1111;
                endcase
            end
            mips_isa_pkg::LWR: rd_lanes = 4'b1111 << k;
            mips_isa_pkg::LW, mips_isa_pkg::LL: rd_lanes = 4'b1111;
            default: rd_lanes = 4'b0000;  // Stores
        endcase
    end

    assign rd_signed = (held.op == mips_isa_pkg::LB) || (held.op == mips_isa_pkg::LH);

    always_comb begin
        case (held.op)
            mips_isa_pkg::SB, mips_isa_pkg::LB, mips_isa_pkg::LBU: size = 2'd0;
            mips_isa_pkg::SH, mips_isa_pkg::LH, mips_isa_pkg::LHU: size = 2'd1;
            default: size = 2'd2;
        endcase
    end

endmodule

//--- source/mem_access_unit.sv
`timescale 1ns/10ps

module mem_access_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  mem_access_pkg::mem_req_t  req_in,
    input  mem_access_pkg::cca_t      config_k0,
    output logic                      ack,
    output mem_access_pkg::mem_resp_t resp
);

    mem_access_pkg::mem_req_t   held;
    mem_access_pkg::paddr_t     paddr;
    mem_access_pkg::exc_info_t  fault;
    mem_access_pkg::lane_mask_t lane_strobe;
    mem_access_pkg::word_t      lane_data;
    mem_access_pkg::lane_mask_t rd_lanes;
    mem_access_pkg::size_t      size;
    logic                       uncached;
    logic                       sc_ok;
    logic                       rd_signed;
    logic                       commit;

    access_ctrl u_access_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_in      (req_in),
        .paddr       (paddr),
        .uncached    (uncached),
        .fault       (fault),
        .sc_ok       (sc_ok),
        .lane_strobe (lane_strobe),
        .lane_data   (lane_data),
        .rd_lanes    (rd_lanes),
        .rd_signed   (rd_signed),
        .size        (size),
        .ack         (ack),
        .held        (held),
        .commit      (commit),
        .resp        (resp)
    );

    addr_translate u_addr_translate (
        .held      (held),
        .config_k0 (config_k0),
        .paddr     (paddr),
        .uncached  (uncached)
    );

    access_fault u_access_fault (
        .held  (held),
        .fault (fault)
    );

    link_monitor u_link_monitor (
        .clk       (clk),
        .rst       (rst),
        .held      (held),
        .commit    (commit),
        .fault_exc (fault.exc),
        .sc_ok     (sc_ok)
    );

    load_format u_load_format (
        .held      (held),
        .rd_lanes  (rd_lanes),
        .rd_signed (rd_signed),
        .size      (size)
    );

    for (genvar i = 0; i < mem_access_pkg::LANES; i++) begin : g_lane
        byte_lane #(
            .LANE (i)
        ) u_byte_lane (
            .held   (held),
            .strobe (lane_strobe[i]),
            .data   (lane_data[8*i +: 8])
        );
    end

endmodule

//--- tests/mem_access_checker.sv
`timescale 1ns/10ps

module mem_access_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      req,
    input logic                      ack,
    input mem_access_pkg::mem_resp_t resp
);

    int fail_count = 0;  // Failed assertions so far

    a_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else begin
            fail_count++;
            $error("ack rose without a pending request");
        end

    a_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else begin
            fail_count++;
            $error("ack fell while req was still high");
        end

    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> $stable(resp))
        else begin
            fail_count++;
            $error("response changed while ack was high");
        end

    // Faulting access must not touch memory
    a_fault_lanes: assert property (@(posedge clk) disable iff (rst)
        (ack && resp.fault.exc) |-> (resp.wr_lanes == '0 && resp.rd_lanes == '0))
        else begin
            fail_count++;
            $error("faulting response has active lanes");
        end

endmodule

bind mem_access_unit mem_access_checker u_mem_access_checker (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .ack  (ack),
    .resp (resp)
);

//--- tests/tb_mem_access_unit.sv
`timescale 1ns/10ps

module tb_mem_access_unit;

    localparam logic [31:0] SEED       = 32'h69336702;
    localparam int          TXNS       = 400;
    localparam int          MAX_CYCLES = TXNS * 12 + 20;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      req;
    mem_access_pkg::mem_req_t  req_in;
    mem_access_pkg::cca_t      config_k0;
    logic                      ack;
    mem_access_pkg::mem_resp_t resp;
    mem_access_pkg::mem_resp_t exp_resp;
    logic [31:0]               lfsr;
    logic                      link;
    mem_access_pkg::vaddr_t    link_addr;
    int                        cycles = 0;
    int                        hold;
    int                        waits;

    mem_access_unit u_mem_access_unit (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_in    (req_in),
        .config_k0 (config_k0),
        .ack       (ack),
        .resp      (resp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (u_mem_access_unit.u_mem_access_checker.fail_count != 0) begin
            $display("A handshake or response assertion failed");
            $display("TEST FAILED");
            $fatal(1);
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic make_request(output mem_access_pkg::mem_req_t r,
                                output mem_access_pkg::cca_t k0, output int hold_cycles);
        logic [31:0] v;
        logic [2:0]  seg;
        take_bits(4, v);
        if (v[3:0] == 4'd14) begin
            r.op = mips_isa_pkg::SC;  // Extra weight on LL and SC
        end else if (v[3:0] == 4'd15) begin
            r.op = mips_isa_pkg::LL;
        end else begin
            r.op = mips_isa_pkg::mem_op_e'(v[3:0]);
        end
        take_bits(2, v);
        case (v[1:0])
            2'd0: seg = 3'b000;
            2'd1: seg = mips_isa_pkg::SEG_KSEG0;
            2'd2: seg = mips_isa_pkg::SEG_KSEG1;
            default: seg = 3'b110;
        endcase
        take_bits(4, v);
        r.vaddr = {seg, 19'h00400, v[3:2], 6'h00, v[1:0]};
        take_bits(2, v);
        if (link && v[1:0] != 2'd3) begin
            r.op    = mips_isa_pkg::SC;  // Follow a live link with its SC
            r.vaddr = link_addr;
        end else if (v[1:0] == 2'd0) begin
            r.vaddr = link_addr;  // Reuse the linked address
        end
        take_bits(32, v);
        r.rt = v;
        take_bits(6, v);
        r.tlb.found = |v[5:4];
        r.tlb.valid = |v[3:2];
        r.tlb.dirty = |v[1:0];
        take_bits(20, v);
        r.tlb.pfn = v[19:0];
        take_bits(3, v);
        r.tlb.cca = v[2:0];
        take_bits(3, v);
        k0 = v[2:0];
        take_bits(2, v);
        hold_cycles = v[1:0];
    endtask

    function automatic mem_access_pkg::mem_resp_t expected_resp(
        input mem_access_pkg::mem_req_t r,
        input mem_access_pkg::cca_t     k0,
        input logic                     lnk,
        input mem_access_pkg::vaddr_t   lnk_addr
    );
        mem_access_pkg::mem_resp_t e;
        logic                      mapped;
        logic                      store;
        logic                      ades;
        logic                      adel;
        logic [1:0]                k;
        e = '0;
        k = r.vaddr[1:0];
        mapped = (r.vaddr[31:30] != 2'b10);  // kuseg, kseg2, kseg3
        store = (r.op <= mips_isa_pkg::SWR) || (r.op == mips_isa_pkg::SC);
        e.paddr = mapped ? {r.tlb.pfn, r.vaddr[11:0]} : {3'b000, r.vaddr[28:0]};
        e.uncached = (r.vaddr[31:29] == mips_isa_pkg::SEG_KSEG1)
            || (r.vaddr[31:29] == mips_isa_pkg::SEG_KSEG0 && k0 != mips_isa_pkg::CCA_CACHEABLE)
            || (mapped && r.tlb.cca != mips_isa_pkg::CCA_CACHEABLE);
        ades = (r.op == mips_isa_pkg::SH && k[0])
            || ((r.op == mips_isa_pkg::SW || r.op == mips_isa_pkg::SC) && k != 2'd0);
        adel = ((r.op == mips_isa_pkg::LH || r.op == mips_isa_pkg::LHU) && k[0])
            || ((r.op == mips_isa_pkg::LW || r.op == mips_isa_pkg::LL) && k != 2'd0);
        if (ades || adel) begin
            e.fault.exc = 1'b1;
            e.fault.code = ades ? mips_isa_pkg::EXC_ADES : mips_isa_pkg::EXC_ADEL;
        end else if (mapped && !(r.tlb.found && r.tlb.valid)) begin
            e.fault.exc = 1'b1;
            e.fault.refill = !r.tlb.found;
            e.fault.code = store ? mips_isa_pkg::EXC_TLBS : mips_isa_pkg::EXC_TLBL;
        end else if (mapped && store && !r.tlb.dirty) begin
            e.fault.exc = 1'b1;
            e.fault.code = mips_isa_pkg::EXC_MOD;
        end
        if (e.fault.exc) begin
            e.fault.badvaddr = r.vaddr;
        end
        e.sc_ok = lnk && r.op == mips_isa_pkg::SC && lnk_addr == r.vaddr && !e.fault.exc;
        for (int i = 0; i < 4; i++) begin
            case (r.op)
                mips_isa_pkg::SB:  e.wr_lanes[i] = (i == k);
                mips_isa_pkg::SH:  e.wr_lanes[i] = (i / 2 == k[1]);
                mips_isa_pkg::SWL: e.wr_lanes[i] = (i <= k);
                mips_isa_pkg::SWR: e.wr_lanes[i] = (i >= k);
                mips_isa_pkg::SW, mips_isa_pkg::SC: e.wr_lanes[i] = 1'b1;
                mips_isa_pkg::LB, mips_isa_pkg::LBU: e.rd_lanes[i] = (i == k);
                mips_isa_pkg::LH, mips_isa_pkg::LHU: e.rd_lanes[i] = (i / 2 == k[1]);
                mips_isa_pkg::LWL: e.rd_lanes[i] = (i <= k);
                mips_isa_pkg::LWR: e.rd_lanes[i] = (i >= k);
                default: e.rd_lanes[i] = 1'b1;  // LW and LL
            endcase
        end
        case (r.op)
            mips_isa_pkg::SB:  e.wdata = {24'h0, r.rt[7:0]} << (8 * k);
            mips_isa_pkg::SH:  e.wdata = k[1] ? {r.rt[15:0], 16'h0} : {16'h0, r.rt[15:0]};
            mips_isa_pkg::SWL: e.wdata = r.rt >> (8 * (3 - k));
            mips_isa_pkg::SWR: e.wdata = r.rt << (8 * k);
            mips_isa_pkg::SW, mips_isa_pkg::SC: e.wdata = r.rt;
            default: e.wdata = '0;
        endcase
        if (e.fault.exc || (r.op == mips_isa_pkg::SC && !e.sc_ok)) begin
            e.wr_lanes = '0;
            e.wdata = '0;
        end
        if (e.fault.exc) begin
            e.rd_lanes = '0;
        end
        e.rd_signed = (r.op == mips_isa_pkg::LB) || (r.op == mips_isa_pkg::LH);
        if (r.op == mips_isa_pkg::SB || r.op == mips_isa_pkg::LB || r.op == mips_isa_pkg::LBU) begin
            e.size = 2'd0;
        end else if (r.op == mips_isa_pkg::SH || r.op == mips_isa_pkg::LH
                     || r.op == mips_isa_pkg::LHU) begin
            e.size = 2'd1;
        end else begin
            e.size = 2'd2;
        end
        return e;
    endfunction

    initial begin
        rst = 1'b1;
        req = 1'b0;
        req_in = '0;
        config_k0 = '0;
        lfsr = SEED;
        link = 1'b0;
        link_addr = 32'h8000_0100;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < TXNS; n++) begin
            make_request(req_in, config_k0, hold);
            exp_resp = expected_resp(req_in, config_k0, link, link_addr);
            req = 1'b1;
            waits = 0;
            do begin
                @(negedge clk);
                waits++;
            end while (!ack);
            check_value("ack_latency", waits, 2);
            check_value("paddr", resp.paddr, exp_resp.paddr);
            check_value("uncached", resp.uncached, exp_resp.uncached);
            check_value("wr_lanes", resp.wr_lanes, exp_resp.wr_lanes);
            check_value("wdata", resp.wdata, exp_resp.wdata);
            check_value("rd_lanes", resp.rd_lanes, exp_resp.rd_lanes);
            check_value("rd_signed", resp.rd_signed, exp_resp.rd_signed);
            check_value("size", resp.size, exp_resp.size);
            check_value("sc_ok", resp.sc_ok, exp_resp.sc_ok);
            check_value("fault.exc", resp.fault.exc, exp_resp.fault.exc);
            check_value("fault.refill", resp.fault.refill, exp_resp.fault.refill);
            check_value("fault.code", resp.fault.code, exp_resp.fault.code);
            check_value("fault.badvaddr", resp.fault.badvaddr, exp_resp.fault.badvaddr);
            if (exp_resp.fault.exc) begin
                link = 1'b0;
            end else if (req_in.op == mips_isa_pkg::LL) begin
                link = 1'b1;
                link_addr = req_in.vaddr;
            end else if (req_in.op == mips_isa_pkg::SC) begin
                link = 1'b0;
            end
            repeat (hold) @(negedge clk);  // Back-pressure
            req = 1'b0;
            @(negedge clk);
            check_value("ack", ack, 1'b0);
        end
        if (u_mem_access_unit.u_mem_access_checker.fail_count != 0) begin
            $display("Handshake or response assertions failed %0d times",
                     u_mem_access_unit.u_mem_access_checker.fail_count);
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- list.f
source/mips_isa_pkg.sv
source/mem_access_pkg.sv
source/access_ctrl.sv
source/addr_translate.sv
source/access_fault.sv
source/link_monitor.sv
source/byte_lane.sv
source/load_format.sv
source/mem_access_unit.sv
tests/mem_access_checker.sv
tests/tb_mem_access_unit.sv
